// ==== Bender.yml ====
package:
  name: periph_bus

sources:
  - periph_pkg.sv
  - periph_bus_ctrl.sv
  - periph_gpio.sv
  - periph_pin_mux.sv
  - periph_byte_regs.sv
  - periph_top.sv
  - target: test
    files:
      - tb_periph_top.sv

// ==== periph_bus_ctrl.sv ====
// Bus controller for the peripheral block
// Address decode, write strobes, read data mux and registered read hold

`timescale 1ns/1ps

module periph_bus_ctrl (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic [periph_pkg::ADDR_W-1:0]                      i_addr,
    input  periph_pkg::access_t                                i_data_write_n,
    input  periph_pkg::access_t                                i_data_read_n,
    input  logic                                               i_data_read_complete,
    input  logic [periph_pkg::DATA_W-1:0]                      i_gpio_rdata,
    input  logic [periph_pkg::SLOT_COUNT*periph_pkg::BYTE_W-1:0] i_simple_rdata,
    output logic                                               o_gpio_wr,
    output logic [periph_pkg::SLOT_COUNT-1:0]                  o_simple_wr,
    output logic [periph_pkg::DATA_W-1:0]                      o_data_out,
    output logic                                               o_data_ready
);
    import periph_pkg::*;

    logic              is_simple;
    slot_idx_t         user_idx;
    slot_idx_t         simple_idx;
    logic              write_req;
    logic              read_req;
    logic              read_peri;
    logic              capture;
    logic [DATA_W-1:0] rdata_mux;
    logic [DATA_W-1:0] data_out_q;
    logic              hold_q;
    logic              ready_q;

    // Region and slot fields of the address
    assign is_simple  = i_addr[SIMPLE_BIT];
    assign user_idx   = i_addr[USER_IDX_LSB +: SLOT_IDX_W];
    assign simple_idx = i_addr[SIMPLE_IDX_LSB +: SLOT_IDX_W];

    assign write_req = (i_data_write_n != ACC_NONE);
    assign read_req  = (i_data_read_n != ACC_NONE);

    // Read is hidden from the slots while the buffered result is presented
    assign read_peri = read_req && !ready_q;

    // All kept slots answer at once, so only the hold gates the capture
    assign capture = read_peri && !hold_q;

    assign o_gpio_wr = write_req && !is_simple && (user_idx == SLOT_GPIO);

    always_comb begin
        o_simple_wr = '0;
        if (write_req && is_simple) begin
            o_simple_wr[simple_idx] = 1'b1;
        end
    end

    // Read data from the addressed slot
    always_comb begin
        rdata_mux = '0;
        if (is_simple) begin
            rdata_mux = {{(DATA_W-BYTE_W){1'b0}}, i_simple_rdata[simple_idx*BYTE_W +: BYTE_W]};
        end else if (user_idx == SLOT_GPIO) begin
            rdata_mux = i_gpio_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            // One cycle behind the request to line up with data_out_q
            ready_q <= read_req;
        end
    end

    // Captured read data, held until the core completes the read
    always_ff @(posedge clk) begin
        if (capture) begin
            data_out_q <= rdata_mux;
        end
    end

    assign o_data_out   = data_out_q;
    assign o_data_ready = ready_q || write_req;

endmodule

// ==== periph_byte_regs.sv ====
// Simple byte peripheral
// Four byte registers, register 0 drives the pin byte

`timescale 1ns/1ps

module periph_byte_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [periph_pkg::SIMPLE_OFS_W-1:0] i_offset,
    input  logic [periph_pkg::BYTE_W-1:0]       i_data_in,
    input  logic                                i_wr,
    output logic [periph_pkg::BYTE_W-1:0]       o_rdata,
    output logic [periph_pkg::PIN_COUNT-1:0]    o_pins
);
    import periph_pkg::*;

    localparam int REG_IDX_W = $clog2(BYTE_REG_COUNT);

    logic [BYTE_W-1:0]    regs_q [BYTE_REG_COUNT];
    logic                 in_range;
    logic [REG_IDX_W-1:0] reg_idx;

    // Offsets past the last register read zero
    assign in_range = (i_offset < BYTE_REG_COUNT);
    assign reg_idx  = i_offset[REG_IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < BYTE_REG_COUNT; r++) begin
                regs_q[r] <= '0;
            end
        end else if (i_wr && in_range) begin
            regs_q[reg_idx] <= i_data_in;
        end
    end

    assign o_rdata = in_range ? regs_q[reg_idx] : '0;
    assign o_pins  = regs_q[0];

endmodule

// ==== periph_gpio.sv ====
// GPIO user peripheral
// Output register, input pin read and per-pin function select registers

`timescale 1ns/1ps

module periph_gpio (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [periph_pkg::USER_OFS_W-1:0]                      i_offset,
    input  logic [periph_pkg::BYTE_W-1:0]                          i_data_in,
    input  logic                                                   i_wr,
    input  logic [periph_pkg::PIN_COUNT-1:0]                       i_ui_in,
    output logic [periph_pkg::DATA_W-1:0]                          o_rdata,
    output logic [periph_pkg::PIN_COUNT-1:0]                       o_gpio_out,
    output logic [periph_pkg::PIN_COUNT*periph_pkg::FUNC_SEL_W-1:0] o_func_sel
);
    import periph_pkg::*;

    localparam int PIN_IDX_W = $clog2(PIN_COUNT);

    logic [PIN_COUNT-1:0]  gpio_out_q;
    logic [FUNC_SEL_W-1:0] func_sel_q [PIN_COUNT];
    logic [USER_OFS_W-1:0] func_rel;
    logic                  func_hit;
    logic [PIN_IDX_W-1:0]  func_idx;

    // Function selects sit on word offsets from GPIO_FUNC_OFS, one per pin
    assign func_rel = i_offset - GPIO_FUNC_OFS;
    assign func_hit = (i_offset >= GPIO_FUNC_OFS) &&
                      (func_rel[1:0] == 2'b00) &&
                      (func_rel < PIN_COUNT*4);
    assign func_idx = func_rel[PIN_IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
            for (int p = 0; p < PIN_COUNT; p++) begin
                func_sel_q[p] <= FUNC_SEL_RESET;
            end
        end else if (i_wr) begin
            if (i_offset == GPIO_OUT_OFS) begin
                gpio_out_q <= i_data_in[PIN_COUNT-1:0];
            end
            if (func_hit) begin
                func_sel_q[func_idx] <= i_data_in[FUNC_SEL_W-1:0];
            end
        end
    end

    // Register read-back
    always_comb begin
        o_rdata = '0;
        if (i_offset == GPIO_OUT_OFS) begin
            o_rdata[PIN_COUNT-1:0] = gpio_out_q;
        end else if (i_offset == GPIO_IN_OFS) begin
            o_rdata[PIN_COUNT-1:0] = i_ui_in;
        end else if (func_hit) begin
            o_rdata[FUNC_SEL_W-1:0] = func_sel_q[func_idx];
        end
    end

    assign o_gpio_out = gpio_out_q;

    // Pack the selects for the pin mux
    for (genvar p = 0; p < PIN_COUNT; p++) begin : g_sel
        assign o_func_sel[p*FUNC_SEL_W +: FUNC_SEL_W] = func_sel_q[p];
    end

endmodule

// ==== periph_pin_mux.sv ====
// Output pin routing
// Each pin takes its bit from GPIO or from the simple slot its select names

`timescale 1ns/1ps

module periph_pin_mux (
    input  logic [periph_pkg::PIN_COUNT*periph_pkg::FUNC_SEL_W-1:0] i_func_sel,
    input  logic [periph_pkg::PIN_COUNT-1:0]                        i_gpio_out,
    input  logic [periph_pkg::SLOT_COUNT*periph_pkg::BYTE_W-1:0]    i_simple_pins,
    output logic [periph_pkg::PIN_COUNT-1:0]                        o_uo_out
);
    import periph_pkg::*;

    for (genvar g = 0; g < PIN_COUNT; g++) begin : g_pin
        logic [FUNC_SEL_W-1:0] sel;
        logic                  to_simple;
        slot_idx_t             src;
        logic [BYTE_W-1:0]     simple_byte;

        assign sel       = i_func_sel[g*FUNC_SEL_W +: FUNC_SEL_W];
        assign to_simple = sel[FUNC_SEL_W-1];
        assign src       = sel[SLOT_IDX_W-1:0];

        // Pin byte of the selected simple slot
        assign simple_byte = i_simple_pins[src*BYTE_W +: BYTE_W];

        // Only GPIO drives pins from the user region
        assign o_uo_out[g] = to_simple          ? simple_byte[g] :
                             (src == SLOT_GPIO) ? i_gpio_out[g]  :
                                                  1'b0;
    end

endmodule

// ==== periph_pkg.sv ====
// Shared definitions for the peripheral bus block
// Bus widths, address map fields, access codes and GPIO register offsets

package periph_pkg;

    // Bus widths
    localparam int ADDR_W = 11;
    localparam int DATA_W = 32;
    localparam int BYTE_W = 8;
    localparam int PIN_COUNT = 8;

    // Slot decode
    localparam int SLOT_COUNT = 16;
    localparam int SLOT_IDX_W = 4;
    localparam int SIMPLE_BIT = 10;
    localparam int USER_IDX_LSB = 6;
    localparam int SIMPLE_IDX_LSB = 4;
    localparam int USER_OFS_W = 6;
    localparam int SIMPLE_OFS_W = 4;

    typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

    localparam slot_idx_t SLOT_GPIO = 4'd1;

    // Pin function select
    // Top bit picks the simple region, low bits give the slot
    localparam int FUNC_SEL_W = 5;
    localparam logic [FUNC_SEL_W-1:0] FUNC_SEL_RESET = {1'b0, SLOT_GPIO};

    // GPIO register offsets
    localparam logic [USER_OFS_W-1:0] GPIO_OUT_OFS = 6'h00;
    localparam logic [USER_OFS_W-1:0] GPIO_IN_OFS = 6'h04;
    localparam logic [USER_OFS_W-1:0] GPIO_FUNC_OFS = 6'h20;

    // Byte register peripheral
    localparam int BYTE_REG_COUNT = 4;

    // Access codes on the read and write request lines
    typedef logic [1:0] access_t;

    localparam access_t ACC_BYTE = 2'b00;
    localparam access_t ACC_HALF = 2'b01;
    localparam access_t ACC_WORD = 2'b10;
    localparam access_t ACC_NONE = 2'b11;

endpackage

// ==== periph_top.sv ====
// Top level of the peripheral bus block
// Bus controller, GPIO, pin routing and byte registers in simple slots 0 and 1

`timescale 1ns/1ps

module periph_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [periph_pkg::ADDR_W-1:0]     i_addr,
    input  logic [periph_pkg::DATA_W-1:0]     i_data_in,
    input  periph_pkg::access_t               i_data_write_n,
    input  periph_pkg::access_t               i_data_read_n,
    output logic [periph_pkg::DATA_W-1:0]     o_data_out,
    output logic                              o_data_ready,
    input  logic                              i_data_read_complete,
    input  logic [periph_pkg::PIN_COUNT-1:0]  i_ui_in,
    output logic [periph_pkg::PIN_COUNT-1:0]  o_uo_out
);
    import periph_pkg::*;

    // Simple slots with a byte register peripheral behind them
    localparam int SIMPLE_USED = 2;

    logic                             gpio_wr;
    logic [SLOT_COUNT-1:0]            simple_wr;
    logic [DATA_W-1:0]                gpio_rdata;
    logic [PIN_COUNT-1:0]             gpio_out;
    logic [PIN_COUNT*FUNC_SEL_W-1:0]  func_sel;
    logic [SLOT_COUNT*BYTE_W-1:0]     simple_rdata;
    logic [SLOT_COUNT*BYTE_W-1:0]     simple_pins;

    periph_bus_ctrl bus_ctrl_inst (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .i_gpio_rdata         (gpio_rdata),
        .i_simple_rdata       (simple_rdata),
        .o_gpio_wr            (gpio_wr),
        .o_simple_wr          (simple_wr),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    periph_gpio gpio_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_offset   (i_addr[USER_OFS_W-1:0]),
        .i_data_in  (i_data_in[BYTE_W-1:0]),
        .i_wr       (gpio_wr),
        .i_ui_in    (i_ui_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    for (genvar s = 0; s < SIMPLE_USED; s++) begin : g_simple
        periph_byte_regs byte_regs_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .i_offset  (i_addr[SIMPLE_OFS_W-1:0]),
            .i_data_in (i_data_in[BYTE_W-1:0]),
            .i_wr      (simple_wr[s]),
            .o_rdata   (simple_rdata[s*BYTE_W +: BYTE_W]),
            .o_pins    (simple_pins[s*BYTE_W +: BYTE_W])
        );
    end

    // Empty simple slots read zero and drive no pins
    assign simple_rdata[SLOT_COUNT*BYTE_W-1:SIMPLE_USED*BYTE_W] = '0;
    assign simple_pins[SLOT_COUNT*BYTE_W-1:SIMPLE_USED*BYTE_W]  = '0;

    periph_pin_mux pin_mux_inst (
        .i_func_sel    (func_sel),
        .i_gpio_out    (gpio_out),
        .i_simple_pins (simple_pins),
        .o_uo_out      (o_uo_out)
    );

endmodule

// ==== tb_periph_top.sv ====
// Testbench for the peripheral bus block
// Clock, reset, bus read and write tasks, assertions, watchdog and report

`timescale 1ns/1ps

module tb_periph_top;
    import periph_pkg::*;

    localparam int CLK_PERIOD = 20;
    // Every bus access counts as one test, rounded up
    localparam int TEST_COUNT = 140;
    localparam int READY_LIMIT = 8;

    logic                 clk;
    logic                 rst_n;
    logic [ADDR_W-1:0]    i_addr;
    logic [DATA_W-1:0]    i_data_in;
    access_t              i_data_write_n;
    access_t              i_data_read_n;
    logic [DATA_W-1:0]    o_data_out;
    logic                 o_data_ready;
    logic                 i_data_read_complete;
    logic [PIN_COUNT-1:0] i_ui_in;
    logic [PIN_COUNT-1:0] o_uo_out;

    int                    errors;
    int unsigned           seed_sink;
    logic [DATA_W-1:0]     rdata;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W-1:0]     held;
    logic [PIN_COUNT-1:0]  gpio_model;
    logic [PIN_COUNT-1:0]  ui_val;
    logic [PIN_COUNT-1:0]  exp_pins;
    logic [BYTE_W-1:0]     byte_model [2][BYTE_REG_COUNT];
    logic [FUNC_SEL_W-1:0] sel_model [PIN_COUNT];
    logic [FUNC_SEL_W-1:0] route_sel [PIN_COUNT];

    periph_top periph_top_inst (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data_in            (i_data_in),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .i_data_read_complete (i_data_read_complete),
        .i_ui_in              (i_ui_in),
        .o_uo_out             (o_uo_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Writes are acknowledged in the cycle they are issued
    write_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (i_data_write_n != ACC_NONE) |-> o_data_ready)
        else begin
            errors++;
            $display("ERROR at %0d ns: write not acknowledged in its own cycle", $time);
        end

    // A fresh read request is answered on the next cycle
    read_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (i_data_read_n != ACC_NONE && !o_data_ready) |=> o_data_ready)
        else begin
            errors++;
            $display("ERROR at %0d ns: read ready did not follow one cycle later", $time);
        end

    // Presented read data holds until the core completes the read
    hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (o_data_ready && i_data_write_n == ACC_NONE && !i_data_read_complete)
        |=> $stable(o_data_out))
        else begin
            errors++;
            $display("ERROR at %0d ns: read data changed before completion", $time);
        end

    function automatic logic [ADDR_W-1:0] user_addr(input int slot, input int ofs);
        return ADDR_W'((slot << USER_IDX_LSB) | ofs);
    endfunction

    function automatic logic [ADDR_W-1:0] simple_addr(input int slot, input int ofs);
        return ADDR_W'((1 << SIMPLE_BIT) | (slot << SIMPLE_IDX_LSB) | ofs);
    endfunction

    task automatic expect_equal(input logic [DATA_W-1:0] actual,
                                input logic [DATA_W-1:0] expected, input string what);
        assert (actual === expected) else begin
            errors++;
            $display("ERROR at %0d ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        @(posedge clk);
        i_addr         <= addr;
        i_data_in      <= data;
        i_data_write_n <= ACC_WORD;
        @(posedge clk);
        i_data_write_n <= ACC_NONE;
    endtask

    // Raise the read and wait for ready, sampled mid-cycle
    task automatic start_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        i_addr        <= addr;
        i_data_read_n <= ACC_WORD;
        @(negedge clk);
        while (!o_data_ready && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        expect_equal(waited, 1, "cycles from read request to ready");
        data = o_data_out;
    endtask

    task automatic finish_read();
        @(posedge clk);
        i_data_read_n        <= ACC_NONE;
        i_data_read_complete <= 1'b1;
        @(posedge clk);
        i_data_read_complete <= 1'b0;
    endtask

    task automatic read_reg(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        start_read(addr, data);
        finish_read();
    endtask

    initial begin
        #(TEST_COUNT * 50 * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", TEST_COUNT * 50);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        errors               = 0;
        seed_sink            = $urandom(98934);
        rst_n                = 1'b0;
        i_addr               = '0;
        i_data_in            = '0;
        i_data_write_n       = ACC_NONE;
        i_data_read_n        = ACC_NONE;
        i_data_read_complete = 1'b0;
        i_ui_in              = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        for (int p = 0; p < PIN_COUNT; p++) begin
            read_reg(user_addr(SLOT_GPIO, GPIO_FUNC_OFS + 4*p), rdata);
            expect_equal(rdata, FUNC_SEL_RESET, "function select after reset");
        end

        // GPIO output, pins and input read
        wdata      = $urandom;
        gpio_model = wdata[PIN_COUNT-1:0];
        write_reg(user_addr(SLOT_GPIO, GPIO_OUT_OFS), wdata);
        @(negedge clk);
        expect_equal(o_uo_out, gpio_model, "pins after GPIO write");
        read_reg(user_addr(SLOT_GPIO, GPIO_OUT_OFS), rdata);
        expect_equal(rdata, gpio_model, "GPIO output read-back");
        ui_val = $urandom;
        @(posedge clk);
        i_ui_in <= ui_val;
        read_reg(user_addr(SLOT_GPIO, GPIO_IN_OFS), rdata);
        expect_equal(rdata, ui_val, "GPIO input read");

        // Held data survives address changes, a new read and a late completion
        @(posedge clk);
        i_ui_in <= ~gpio_model;
        start_read(user_addr(SLOT_GPIO, GPIO_OUT_OFS), held);
        expect_equal(held, gpio_model, "held read data");
        for (int c = 0; c < 5; c++) begin
            @(posedge clk);
            i_addr <= user_addr(SLOT_GPIO, GPIO_IN_OFS);
            if (c == 2) begin
                i_data_read_n <= ACC_NONE;
            end
            if (c == 3) begin
                i_data_read_n <= ACC_WORD;
            end
            @(negedge clk);
            expect_equal(o_data_out, held, "read data before completion");
        end
        finish_read();

        for (int p = 0; p < PIN_COUNT; p++) begin
            wdata        = $urandom;
            sel_model[p] = wdata[FUNC_SEL_W-1:0];
            write_reg(user_addr(SLOT_GPIO, GPIO_FUNC_OFS + 4*p), wdata);
        end
        for (int p = 0; p < PIN_COUNT; p++) begin
            read_reg(user_addr(SLOT_GPIO, GPIO_FUNC_OFS + 4*p), rdata);
            expect_equal(rdata, sel_model[p], "function select read-back");
        end

        // Byte registers, writes past offset 3 must be ignored
        for (int s = 0; s < 2; s++) begin
            for (int o = 0; o < 16; o++) begin
                wdata = $urandom;
                if (o < BYTE_REG_COUNT) begin
                    byte_model[s][o] = wdata[BYTE_W-1:0];
                end
                write_reg(simple_addr(s, o), wdata);
            end
        end
        for (int s = 0; s < 2; s++) begin
            for (int o = 0; o < 16; o++) begin
                read_reg(simple_addr(s, o), rdata);
                expect_equal(rdata, (o < BYTE_REG_COUNT) ? byte_model[s][o] : 8'h00,
                             "byte register read-back");
            end
        end

        for (int s = 0; s < SLOT_COUNT; s++) begin
            if (s != SLOT_GPIO) begin
                read_reg(user_addr(s, 0), rdata);
                expect_equal(rdata, 0, "empty user slot read");
            end
        end
        for (int s = 2; s < SLOT_COUNT; s++) begin
            read_reg(simple_addr(s, 0), rdata);
            expect_equal(rdata, 0, "empty simple slot read");
        end

        // Pin routing, GPIO all high so empty sources show as zero
        gpio_model = '1;
        write_reg(user_addr(SLOT_GPIO, GPIO_OUT_OFS), 32'hFF);
        route_sel = '{5'h10, 5'h10, 5'h11, 5'h11, 5'h01, 5'h03, 5'h19, 5'h10};
        for (int p = 0; p < PIN_COUNT; p++) begin
            write_reg(user_addr(SLOT_GPIO, GPIO_FUNC_OFS + 4*p), route_sel[p]);
        end
        for (int p = 0; p < PIN_COUNT; p++) begin
            if (route_sel[p][FUNC_SEL_W-1]) begin
                exp_pins[p] = (route_sel[p][3:0] < 2) ? byte_model[route_sel[p][3:0]][0][p] : 1'b0;
            end else begin
                exp_pins[p] = (route_sel[p][3:0] == SLOT_GPIO) ? gpio_model[p] : 1'b0;
            end
        end
        @(negedge clk);
        expect_equal(o_uo_out, exp_pins, "routed output pins");

        repeat (2) @(posedge clk);
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
periph_pkg.sv
periph_bus_ctrl.sv
periph_gpio.sv
periph_pin_mux.sv
periph_byte_regs.sv
periph_top.sv
tb_periph_top.sv
